/* design/lockstep_cfg_pkg.sv */
/*
 * Configuration defaults for the lockstep checker
 *   lane count and lane sample width
 *   accumulator width
 *   lockstep offset of the shadow core
 */
`default_nettype none

package lockstep_cfg_pkg;

  // Accumulator lanes in the core
  parameter int unsigned NumLanes = 4;

  // Width of one lane sample
  parameter int unsigned DataWidth = 8;

  // Accumulator width, sums wrap at this size
  parameter int unsigned AccWidth = 16;

  // Shadow core delay in cycles, at least 2
  parameter int unsigned LockstepOffset = 2;

endpackage

`default_nettype wire

/* design/lockstep_types_pkg.sv */
/*
 * Vector types shared between the checker blocks
 *   lane sample, accumulator value
 *   per-lane mismatch mask
 *   shadow reset counter value
 */
`default_nettype none

package lockstep_types_pkg;
  import lockstep_cfg_pkg::*;

  // Counter must reach LockstepOffset - 1
  localparam int unsigned OffsetCntWidth = $clog2(LockstepOffset + 1);

  typedef logic [DataWidth-1:0] lane_data_t;

  typedef logic [AccWidth-1:0] acc_t;

  // One bit per lane
  typedef logic [NumLanes-1:0] lane_mask_t;

  typedef logic [OffsetCntWidth-1:0] offset_cnt_t;

endpackage

`default_nettype wire

/* design/shadow_reset_gen.sv */
/*
 * Shadow core reset sequencer
 *   holds the shadow lanes in reset for LockstepOffset cycles
 *   after the system reset, then enables the comparison
 *   one cycle later
 */
`default_nettype none

module shadow_reset_gen import lockstep_types_pkg::*; #(
  parameter int unsigned LockstepOffset = lockstep_cfg_pkg::LockstepOffset
) (
  input  logic clk_i,
  input  logic rst_ni,
  output logic shadow_rst_no,
  output logic cmp_en_o
);

  offset_cnt_t cnt_d;
  offset_cnt_t cnt_q;
  logic        set_d;
  logic        set_q;
  logic        cmp_en_q;

  // Final count reached, release the shadow reset next cycle
  assign set_d = (cnt_q == offset_cnt_t'(LockstepOffset - 1));

  // Counter stops at its end value
  assign cnt_d = set_d ? cnt_q : cnt_q + offset_cnt_t'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q    <= '0;
      set_q    <= 1'b0;
      cmp_en_q <= 1'b0;
    end else begin
      cnt_q    <= cnt_d;
      set_q    <= set_d;
      cmp_en_q <= set_q;
    end
  end

  // Registered flag is the active-low shadow reset
  assign shadow_rst_no = set_q;

  // Compare only once the shadow register holds post-reset data
  assign cmp_en_o      = cmp_en_q;

endmodule

`default_nettype wire

/* design/input_delay_line.sv */
/*
 * Input delay line of the shadow core
 *   shifts valid, clear and the lane samples by
 *   LockstepOffset cycles so the shadow lanes see the
 *   stimulus of the main core late by a fixed amount
 */
`default_nettype none

module input_delay_line import lockstep_types_pkg::*; #(
  parameter int unsigned NumLanes       = lockstep_cfg_pkg::NumLanes,
  parameter int unsigned LockstepOffset = lockstep_cfg_pkg::LockstepOffset
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      valid_i,
  input  logic                      clear_i,
  input  lane_data_t [NumLanes-1:0] lane_data_i,
  output logic                      valid_o,
  output logic                      clear_o,
  output lane_data_t [NumLanes-1:0] lane_data_o
);

  // Top stage takes the input, stage 0 feeds the shadow core
  logic [LockstepOffset-1:0]                     valid_q;
  logic [LockstepOffset-1:0]                     clear_q;
  lane_data_t [LockstepOffset-1:0][NumLanes-1:0] data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      clear_q <= '0;
      data_q  <= '0;
    end else begin
      for (int unsigned i = 0; i < LockstepOffset - 1; i++) begin
        valid_q[i] <= valid_q[i+1];
        clear_q[i] <= clear_q[i+1];
        data_q[i]  <= data_q[i+1];
      end
      valid_q[LockstepOffset-1] <= valid_i;
      clear_q[LockstepOffset-1] <= clear_i;
      data_q[LockstepOffset-1]  <= lane_data_i;
    end
  end

  assign valid_o     = valid_q[0];
  assign clear_o     = clear_q[0];
  assign lane_data_o = data_q[0];

endmodule

`default_nettype wire

/* design/acc_lane.sv */
/*
 * One accumulator lane of the shadow core
 *   clear zeroes the sum and wins over valid
 *   valid adds the zero-extended sample, modulo 2^AccWidth
 */
`default_nettype none

module acc_lane import lockstep_types_pkg::*; #(
  parameter int unsigned DataWidth = lockstep_cfg_pkg::DataWidth,
  parameter int unsigned AccWidth  = lockstep_cfg_pkg::AccWidth
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       valid_i,
  input  logic       clear_i,
  input  lane_data_t data_i,
  output acc_t       acc_o
);

  acc_t acc_q;
  acc_t sample_ext;

  assign sample_ext = {{(AccWidth - DataWidth){1'b0}}, data_i};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (clear_i) begin
      acc_q <= '0;
    end else if (valid_i) begin
      acc_q <= acc_q + sample_ext;
    end
  end

  assign acc_o = acc_q;

endmodule

`default_nettype wire

/* design/output_compare.sv */
/*
 * Output comparator of the lockstep checker
 *   delays the main core outputs by LockstepOffset + 1
 *   registers the shadow outputs once
 *   compares per lane and raises the major alert
 */
`default_nettype none

module output_compare import lockstep_types_pkg::*; #(
  parameter int unsigned NumLanes       = lockstep_cfg_pkg::NumLanes,
  parameter int unsigned LockstepOffset = lockstep_cfg_pkg::LockstepOffset
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                cmp_en_i,
  input  acc_t [NumLanes-1:0] shadow_acc_i,
  input  acc_t [NumLanes-1:0] main_acc_i,
  output lane_mask_t          mismatch_lanes_o,
  output logic                alert_major_o
);

  // Extra stage matches the shadow output register
  localparam int unsigned OutputsOffset = LockstepOffset + 1;

  acc_t [OutputsOffset-1:0][NumLanes-1:0] main_q;
  acc_t [NumLanes-1:0]                    shadow_q;
  lane_mask_t                             lane_diff;

  //////////////////////////////
  // Alignment registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      main_q   <= '0;
      shadow_q <= '0;
    end else begin
      for (int unsigned i = 0; i < OutputsOffset - 1; i++) begin
        main_q[i] <= main_q[i+1];
      end
      main_q[OutputsOffset-1] <= main_acc_i;
      shadow_q                <= shadow_acc_i;
    end
  end

  //////////////////////////////
  // Compare
  //////////////////////////////

  always_comb begin
    for (int unsigned i = 0; i < NumLanes; i++) begin
      lane_diff[i] = (shadow_q[i] != main_q[0][i]);
    end
  end

  // No report until the shadow lanes run in step
  assign mismatch_lanes_o = cmp_en_i ? lane_diff : '0;
  assign alert_major_o    = |mismatch_lanes_o;

endmodule

`default_nettype wire

/* design/lockstep_top.sv */
/*
 * Top level of the lockstep checker
 *   shadow reset sequencer, input delay line,
 *   bank of shadow accumulator lanes and the
 *   output comparator with the major alert
 */
`default_nettype none

module lockstep_top import lockstep_types_pkg::*; #(
  parameter int unsigned NumLanes       = lockstep_cfg_pkg::NumLanes,
  parameter int unsigned DataWidth      = lockstep_cfg_pkg::DataWidth,
  parameter int unsigned AccWidth       = lockstep_cfg_pkg::AccWidth,
  parameter int unsigned LockstepOffset = lockstep_cfg_pkg::LockstepOffset
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      valid_i,
  input  logic                      clear_i,
  input  lane_data_t [NumLanes-1:0] lane_data_i,
  input  acc_t [NumLanes-1:0]       main_acc_i,
  output lane_mask_t                mismatch_lanes_o,
  output logic                      alert_major_o
);

  logic                      shadow_rst_n;
  logic                      cmp_en;
  logic                      dly_valid;
  logic                      dly_clear;
  lane_data_t [NumLanes-1:0] dly_lane_data;
  acc_t [NumLanes-1:0]       shadow_acc;

  //////////////////////////////
  // Reset and input delay
  //////////////////////////////

  shadow_reset_gen #(
    .LockstepOffset(LockstepOffset)
  ) u_reset_gen (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .shadow_rst_no(shadow_rst_n),
    .cmp_en_o     (cmp_en)
  );

  input_delay_line #(
    .NumLanes      (NumLanes),
    .LockstepOffset(LockstepOffset)
  ) u_delay_line (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .valid_i    (valid_i),
    .clear_i    (clear_i),
    .lane_data_i(lane_data_i),
    .valid_o    (dly_valid),
    .clear_o    (dly_clear),
    .lane_data_o(dly_lane_data)
  );

  //////////////////////////////
  // Shadow core
  //////////////////////////////

  for (genvar i = 0; i < NumLanes; i++) begin : g_lane
    acc_lane #(
      .DataWidth(DataWidth),
      .AccWidth (AccWidth)
    ) u_lane (
      .clk_i  (clk_i),
      .rst_ni (shadow_rst_n),
      .valid_i(dly_valid),
      .clear_i(dly_clear),
      .data_i (dly_lane_data[i]),
      .acc_o  (shadow_acc[i])
    );
  end

  output_compare #(
    .NumLanes      (NumLanes),
    .LockstepOffset(LockstepOffset)
  ) u_compare (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cmp_en_i        (cmp_en),
    .shadow_acc_i    (shadow_acc),
    .main_acc_i      (main_acc_i),
    .mismatch_lanes_o(mismatch_lanes_o),
    .alert_major_o   (alert_major_o)
  );

endmodule

`default_nettype wire

/* bench/lockstep_checker.sv */
/*
 * Bound assertions on the lockstep checker outputs
 *   major alert follows the mismatch mask
 *   no mismatch while the shadow core is in reset
 *   outputs known out of reset
 */
`default_nettype none

module lockstep_checker import lockstep_types_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       shadow_rst_ni,
  input lane_mask_t mismatch_lanes_i,
  input logic       alert_major_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Failed assertions so far, read by the testbench
  int unsigned failures = 0;

  alert_is_mask_or: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_major_i == |mismatch_lanes_i)
    else begin
      $error("alert_major_o differs from the OR of the mismatch mask");
      failures++;
    end

  quiet_in_shadow_reset: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !shadow_rst_ni |-> mismatch_lanes_i == '0)
    else begin
      $error("mismatch mask set while the shadow lanes are in reset");
      failures++;
    end

  outputs_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({alert_major_i, mismatch_lanes_i}))
    else begin
      $error("alert outputs unknown out of reset");
      failures++;
    end

endmodule

`default_nettype wire

/* bench/tb_lockstep.sv */
/*
 * Directed testbench of the lockstep checker
 *   main core model with fault injection
 *   reset window, matched run, single and multi-lane faults,
 *   clear and wrap of the accumulators
 */
`default_nettype none

module tb_lockstep import lockstep_cfg_pkg::*, lockstep_types_pkg::*;;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned AlertTimeout = 4 * LockstepOffset + 8;
  localparam int unsigned WrapCycles   = (1 << AccWidth) / ((1 << DataWidth) - 1) + 8;
  localparam int unsigned FaultLane    = 1;

  logic                      clk_i = 1'b0;
  logic                      rst_ni;
  logic                      valid_i;
  logic                      clear_i;
  lane_data_t [NumLanes-1:0] lane_data_i;
  acc_t [NumLanes-1:0]       main_acc;
  lane_mask_t                mismatch_lanes_o;
  logic                      alert_major_o;

  // Main core model state and the injected error per lane
  acc_t [NumLanes-1:0]       ref_acc;
  acc_t [NumLanes-1:0]       fault_add;
  logic [31:0]               rng_state = 32'h80fc_128c;

  always #50 clk_i = ~clk_i;

  lockstep_top #(
    .NumLanes      (NumLanes),
    .DataWidth     (DataWidth),
    .AccWidth      (AccWidth),
    .LockstepOffset(LockstepOffset)
  ) i_dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .valid_i         (valid_i),
    .clear_i         (clear_i),
    .lane_data_i     (lane_data_i),
    .main_acc_i      (main_acc),
    .mismatch_lanes_o(mismatch_lanes_o),
    .alert_major_o   (alert_major_o)
  );

  bind lockstep_top lockstep_checker i_checker (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .shadow_rst_ni   (shadow_rst_n),
    .mismatch_lanes_i(mismatch_lanes_o),
    .alert_major_i   (alert_major_o)
  );

  //////////////////////////////
  // Main core model
  //////////////////////////////

  // Updates on the edge that samples the strobes, clear first
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ref_acc <= '0;
    end else begin
      for (int i = 0; i < NumLanes; i++) begin
        if (clear_i) begin
          ref_acc[i] <= '0;
        end else if (valid_i) begin
          ref_acc[i] <= ref_acc[i] + acc_t'(lane_data_i[i]);
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NumLanes; i++) begin
      main_acc[i] = ref_acc[i] + fault_add[i];
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1);
  endtask

  // Stop at the first failed assertion of the bound checker
  always @(negedge clk_i) begin
    if (i_dut.i_checker.failures != 0) begin
      $display("A bound assertion on the alert outputs failed");
      abort_run();
    end
  end

  task automatic check_mask(input lane_mask_t actual, input lane_mask_t expected);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: mismatch_lanes_o = %b, expected %b", $time, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_alert(input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: alert_major_o = %b, expected %b", $time, actual, expected);
      abort_run();
    end
  endtask

  task automatic expect_outputs(input lane_mask_t expected);
    check_mask(mismatch_lanes_o, expected);
    check_alert(alert_major_o, |expected);
  endtask

  task automatic drive_idle();
    valid_i     = 1'b0;
    clear_i     = 1'b0;
    lane_data_i = '0;
  endtask

  // Mostly valid, now and then a clear
  task automatic drive_random_cycle();
    logic [31:0] r;
    r       = next_rand();
    valid_i = (r[1:0] != 2'b00);
    clear_i = (r[7:4] == 4'h0);
    for (int i = 0; i < NumLanes; i++) begin
      lane_data_i[i] = lane_data_t'(next_rand());
    end
  endtask

  task automatic settle_quiet(input int unsigned cycles);
    drive_idle();
    for (int unsigned i = 0; i < cycles; i++) begin
      @(negedge clk_i);
      expect_outputs('0);
    end
  endtask

  // Fault on main_acc for one cycle, then measure when the alert rises
  task automatic inject_and_measure(input lane_mask_t lanes);
    int unsigned cycles;
    @(negedge clk_i);
    expect_outputs('0);
    drive_random_cycle();
    for (int i = 0; i < NumLanes; i++) begin
      if (lanes[i]) fault_add[i] = acc_t'(next_rand() | 32'd1);
    end
    @(negedge clk_i);
    fault_add = '0;
    cycles    = 1;
    while (!alert_major_o && cycles < AlertTimeout) begin
      check_mask(mismatch_lanes_o, '0);
      drive_random_cycle();
      @(negedge clk_i);
      cycles++;
    end
    if (!alert_major_o) begin
      $display("Timeout: no alert within %0d cycles of the injected fault", AlertTimeout);
      abort_run();
    end
    if (cycles != LockstepOffset + 1) begin
      $display("Alert rose %0d cycles after the fault instead of %0d", cycles,
               LockstepOffset + 1);
      abort_run();
    end
    expect_outputs(lanes);
    drive_random_cycle();
    @(negedge clk_i);
    expect_outputs('0);
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic reset_window();
    fault_add[FaultLane] = acc_t'(16'h0055);
    for (int i = 0; i < 10; i++) begin
      @(negedge clk_i);
      expect_outputs('0);
    end
    rst_ni = 1'b1;
    for (int i = 0; i <= LockstepOffset; i++) begin
      if (i > 0) @(negedge clk_i);
      expect_outputs('0);
    end
    fault_add = '0;
    // Samples taken by the first LockstepOffset edges reach the compare now
    for (int i = 0; i < LockstepOffset; i++) begin
      @(negedge clk_i);
      expect_outputs(lane_mask_t'(1) << FaultLane);
    end
    settle_quiet(1);
  endtask

  task automatic matched_run();
    for (int i = 0; i < 200; i++) begin
      @(negedge clk_i);
      expect_outputs('0);
      drive_random_cycle();
    end
    settle_quiet(LockstepOffset + 1);
  endtask

  task automatic single_lane_fault();
    for (int k = 0; k < NumLanes; k++) begin
      inject_and_measure(lane_mask_t'(1) << k);
    end
  endtask

  task automatic multi_lane_fault();
    inject_and_measure(lane_mask_t'(32'hB));
    inject_and_measure('1);
  endtask

  task automatic clear_and_wrap();
    valid_i     = 1'b1;
    clear_i     = 1'b0;
    lane_data_i = '1;
    for (int unsigned i = 0; i < WrapCycles; i++) begin
      @(negedge clk_i);
      expect_outputs('0);
    end
    // Valid stays high while clear is set
    clear_i = 1'b1;
    @(negedge clk_i);
    expect_outputs('0);
    clear_i = 1'b0;
    for (int i = 0; i < 20; i++) begin
      @(negedge clk_i);
      expect_outputs('0);
    end
    settle_quiet(LockstepOffset + 1);
  endtask

  initial begin
    rst_ni    = 1'b0;
    fault_add = '0;
    drive_idle();
    reset_window();
    matched_run();
    single_lane_fault();
    multi_lane_fault();
    clear_and_wrap();
    if (i_dut.i_checker.failures == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("%0d assertion failures", i_dut.i_checker.failures);
      abort_run();
    end
  end

endmodule

`default_nettype wire

/* tb.f */
design/lockstep_cfg_pkg.sv
design/lockstep_types_pkg.sv
design/shadow_reset_gen.sv
design/input_delay_line.sv
design/acc_lane.sv
design/output_compare.sv
design/lockstep_top.sv
bench/lockstep_checker.sv
bench/tb_lockstep.sv

/* Bender.yml */
package:
  name: lockstep_checker

sources:
  - design/lockstep_cfg_pkg.sv
  - design/lockstep_types_pkg.sv
  - design/shadow_reset_gen.sv
  - design/input_delay_line.sv
  - design/acc_lane.sv
  - design/output_compare.sv
  - design/lockstep_top.sv
  - target: test
    files:
      - bench/lockstep_checker.sv
      - bench/tb_lockstep.sv
